// ==== code_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "ffe_defs.svh"

// holds the older blocks of the window. the incoming block is appended
// as the newest slot of the flat view, so the view is the history as it
// stands once that block has been shifted in.
module code_buffer #(
	parameter int numChannels = `FFE_CHANNELS,
	parameter int bitwidth = `FFE_CODE_WIDTH,
	parameter int depth = `FFE_BUFFER_DEPTH
) (
	input wire logic clk,
	input wire logic rstb,
	input wire logic advance,
	input wire ffe_pkg::codeBlock_t in,
	output logic [numChannels*depth-1:0][bitwidth-1:0] flatCodes
);

	// index 0 is the oldest block.
	logic [depth-2:0][numChannels-1:0][bitwidth-1:0] blocks;
	logic [numChannels-1:0][bitwidth-1:0] newest;

	assign newest = in.codes;

	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			blocks <= '0; // history starts at zero.
		end else if (advance) begin
			for (int b = 0; b < depth - 2; b++) begin
				blocks[b] <= blocks[b + 1];
			end
			blocks[depth-2] <= newest;
		end
	end

	// oldest code at flat index 0, newest block on top.
	always_comb begin
		for (int b = 0; b < depth; b++) begin
			for (int c = 0; c < numChannels; c++) begin
				if (b == depth - 1) begin
					flatCodes[b*numChannels + c] = newest[c];
				end else begin
					flatCodes[b*numChannels + c] = blocks[b][c];
				end
			end
		end
	end

endmodule : code_buffer

`default_nettype wire

// ==== comb_ffe.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "ffe_defs.svh"

module comb_ffe #(
	parameter int ffeDepth = `FFE_DEPTH,
	parameter int numChannels = `FFE_CHANNELS,
	parameter int numBuffers = `FFE_BUFFER_DEPTH,
	parameter int centerBuffer = `FFE_CENTER_BUFFER
) (
	input wire ffe_pkg::weightSet_t weights,
	input wire ffe_pkg::shiftSet_t shiftIndex,
	input wire logic [numChannels*numBuffers-1:0][`FFE_CODE_WIDTH-1:0] flatCodes,
	output ffe_pkg::result_t [numChannels-1:0] estimatedCodes
);

	// full growth of ffeDepth products.
	localparam int accWidth = `FFE_CODE_WIDTH + `FFE_WEIGHT_WIDTH + $clog2(ffeDepth);
	localparam int startIdx = centerBuffer * numChannels;

	localparam logic signed [accWidth-1:0] satMax = 2 ** (`FFE_RESULT_WIDTH - 1) - 1;
	localparam logic signed [accWidth-1:0] satMin = -(2 ** (`FFE_RESULT_WIDTH - 1));

	logic signed [accWidth-1:0] sums [numChannels];
	logic signed [accWidth-1:0] shifted [numChannels];
	logic signed [`FFE_CODE_WIDTH-1:0] tapCode [numChannels][ffeDepth];

	// code seen by each tap, channel c starts c codes after the center block.
	always_comb begin
		for (int c = 0; c < numChannels; c++) begin
			for (int t = 0; t < ffeDepth; t++) begin
				tapCode[c][t] = $signed(flatCodes[startIdx + c + t]);
			end
		end
	end

	// multiply-accumulate.
	always_comb begin
		for (int c = 0; c < numChannels; c++) begin
			sums[c] = '0;
			for (int t = 0; t < ffeDepth; t++) begin
				sums[c] = sums[c] + weights[t][c] * tapCode[c][t]; // signed, sized to acc.
			end
		end
	end

	// arithmetic shift then clamp to the result range.
	always_comb begin
		for (int c = 0; c < numChannels; c++) begin
			shifted[c] = sums[c] >>> shiftIndex[c];
			if (shifted[c] > satMax) begin
				estimatedCodes[c] = satMax[`FFE_RESULT_WIDTH-1:0];
			end else if (shifted[c] < satMin) begin
				estimatedCodes[c] = satMin[`FFE_RESULT_WIDTH-1:0];
			end else begin
				estimatedCodes[c] = shifted[c][`FFE_RESULT_WIDTH-1:0];
			end
		end
	end

endmodule : comb_ffe

`default_nettype wire

// ==== ffe_coef_regs.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "ffe_defs.svh"

module ffe_coef_regs (
	input wire logic clk,
	input wire logic rstb,
	input wire ffe_pkg::cfgCmd_t cfgCmd,
	output ffe_pkg::weightSet_t weights,
	output ffe_pkg::shiftSet_t shiftIndex
);
	import ffe_pkg::*;

	logic tapOk;

	// tap field is wider than the range it addresses.
	assign tapOk = (cfgCmd.tap < `FFE_DEPTH);

	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			weights <= '0;
			shiftIndex <= '0;
		end else begin
			case (cfgCmd.op)
				cfgWeight: begin
					if (tapOk) begin
						weights[cfgCmd.tap][cfgCmd.channel] <= cfgCmd.value;
					end
				end
				cfgShift: begin
					shiftIndex[cfgCmd.channel] <= cfgCmd.value[`FFE_SHIFT_WIDTH-1:0];
				end
				default: begin
					weights <= weights; // nop.
				end
			endcase
		end
	end

endmodule : ffe_coef_regs

`default_nettype wire

// ==== ffe_credit_in.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "ffe_defs.svh"

module ffe_credit_in #(
	parameter int depth = `FFE_IN_FIFO_DEPTH
) (
	input wire logic clk,
	input wire logic rstb,
	input wire ffe_pkg::codeBlock_t inBlock,
	input wire logic pop,
	output ffe_pkg::codeBlock_t outBlock,
	output logic notEmpty,
	output logic inCreditReturn
);
	import ffe_pkg::*;

	localparam int ptrWidth = (depth > 1) ? $clog2(depth) : 1;
	localparam int countWidth = $clog2(depth + 1);

	codeBlock_t mem [depth];
	logic [ptrWidth-1:0] wrPtr;
	logic [ptrWidth-1:0] rdPtr;
	logic [countWidth-1:0] count;
	logic push;
	logic doPop;

	assign notEmpty = (count != '0);
	// upstream only sends on a credit, so full never meets a push.
	assign push = inBlock.valid && (count != countWidth'(depth));
	assign doPop = pop && notEmpty;
	assign inCreditReturn = doPop; // one credit back per popped block.

	always_comb begin
		outBlock = mem[rdPtr]; // head entry.
		outBlock.valid = notEmpty;
	end

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wrPtr] <= inBlock;
		end
	end

	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wrPtr <= (wrPtr == ptrWidth'(depth - 1)) ? '0 : wrPtr + 1'b1;
			end
			if (doPop) begin
				rdPtr <= (rdPtr == ptrWidth'(depth - 1)) ? '0 : rdPtr + 1'b1;
			end
			case ({push, doPop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count; // both or neither.
			endcase
		end
	end

endmodule : ffe_credit_in

`default_nettype wire

// ==== ffe_defs.svh ====
`ifndef FFE_DEFS_SVH
`define FFE_DEFS_SVH

// datapath widths.
`define FFE_CODE_WIDTH 8
`define FFE_WEIGHT_WIDTH 8
`define FFE_RESULT_WIDTH 8
`define FFE_SHIFT_WIDTH 5

// equalizer shape.
`define FFE_DEPTH 6
`define FFE_CHANNELS 4

// blocks of history needed to cover every tap, current block included.
`define FFE_BUFFER_DEPTH (((`FFE_DEPTH - 1 + `FFE_CHANNELS - 1) / `FFE_CHANNELS) + 1)
`define FFE_CENTER_BUFFER 0

// input FIFO entries, also the upstream credits after reset.
`define FFE_IN_FIFO_DEPTH 4

// downstream buffer size, also the credits the core starts with.
`define FFE_OUT_CREDITS 2

`endif

// ==== ffe_pkg.sv ====
`default_nettype none
`include "ffe_defs.svh"

package ffe_pkg;

	typedef logic signed [`FFE_CODE_WIDTH-1:0] code_t;
	typedef logic signed [`FFE_WEIGHT_WIDTH-1:0] weight_t;
	typedef logic signed [`FFE_RESULT_WIDTH-1:0] result_t;
	typedef logic [`FFE_SHIFT_WIDTH-1:0] shift_t;

	// one input transfer, channel 0 is the oldest code of the block.
	typedef struct packed {
		logic valid;
		code_t [`FFE_CHANNELS-1:0] codes;
	} codeBlock_t;

	// one output transfer.
	typedef struct packed {
		logic valid;
		result_t [`FFE_CHANNELS-1:0] results;
	} resultBlock_t;

	typedef weight_t [`FFE_DEPTH-1:0][`FFE_CHANNELS-1:0] weightSet_t; // [tap][channel].
	typedef shift_t [`FFE_CHANNELS-1:0] shiftSet_t;

	typedef enum logic [1:0] {
		cfgNop,
		cfgWeight,
		cfgShift
	} cfgOp_t;

	typedef struct packed {
		cfgOp_t op;
		logic [$clog2(`FFE_DEPTH)-1:0] tap;
		logic [$clog2(`FFE_CHANNELS)-1:0] channel;
		weight_t value; // shift uses the low bits.
	} cfgCmd_t;

endpackage : ffe_pkg

`default_nettype wire

// ==== ffe_tb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "ffe_defs.svh"

module ffe_tb;
	import ffe_pkg::*;

	localparam int clkPeriod = 20;
	localparam int bufDepth = `FFE_BUFFER_DEPTH;
	localparam int satMax = 2 ** (`FFE_RESULT_WIDTH - 1) - 1;
	localparam int satMin = -(2 ** (`FFE_RESULT_WIDTH - 1));
	localparam int totalBlocks = 4 + 40 + 64 + 6 + 16;
	localparam int worstGap = 12; // input gap plus credit return gap per block.
	localparam int runLimit = (totalBlocks * worstGap + 2000) * clkPeriod;
	localparam logic [31:0] seed = 32'd56;

	logic clk = 1'b0;
	logic rstb = 1'b0;
	codeBlock_t inBlock = '0;
	cfgCmd_t cfgCmd = '0;
	logic outCreditReturn = 1'b0;
	logic inCreditReturn;
	resultBlock_t outBlock;

	codeBlock_t txQueue[$];
	codeBlock_t sentBlocks[$];
	int modelWeight [`FFE_DEPTH][`FFE_CHANNELS] = '{default: 0};
	int modelShift [`FFE_CHANNELS] = '{default: 0};
	int upCredits = `FFE_IN_FIFO_DEPTH;
	int creditPulses = 0;
	int outCount = 0;
	int returnsGiven = 0;
	int pendingReturns = 0;
	int maxGap = 0;
	int txGap = 0;
	int rxGap = 0;
	int satHigh = 0;
	int satLow = 0;
	logic withhold = 1'b0;
	logic [31:0] mainState = seed;
	logic [31:0] txState = seed ^ 32'h9e3779b9;
	logic [31:0] rxState = seed ^ 32'h7f4a7c15;

	ffe_top u_dut (
		.clk(clk),
		.rstb(rstb),
		.inBlock(inBlock),
		.inCreditReturn(inCreditReturn),
		.cfgCmd(cfgCmd),
		.outBlock(outBlock),
		.outCreditReturn(outCreditReturn)
	);

	always #(clkPeriod / 2) clk = ~clk;

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	task automatic stopOnError(input string msg);
		$display("Error at %0t ns: %s", $time, msg);
		$display("TESTS FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	// flat index 0 is the oldest code, blocks before the first input are zero.
	function automatic int codeAt(input int k, input int i);
		int b;
		b = k + i / `FFE_CHANNELS - (bufDepth - 1);
		if (b < 0) begin
			return 0;
		end
		return $signed(sentBlocks[b].codes[i % `FFE_CHANNELS]);
	endfunction

	function automatic int expectedResult(input int k, input int c);
		int sum = 0;
		for (int t = 0; t < `FFE_DEPTH; t++) begin
			sum += modelWeight[t][c] * codeAt(k, c + t);
		end
		sum = sum >>> modelShift[c];
		return (sum > satMax) ? satMax : ((sum < satMin) ? satMin : sum);
	endfunction

	// upstream side. a returned credit is spent from the next cycle on.
	always @(negedge clk) begin
		inBlock.valid = 1'b0;
		if (txGap > 0) begin
			txGap--;
		end else if (rstb && txQueue.size() > 0 && upCredits > 0) begin
			inBlock = txQueue.pop_front();
			inBlock.valid = 1'b1;
			sentBlocks.push_back(inBlock);
			upCredits--;
			txState = xorshift(txState);
			txGap = txState % (maxGap + 1);
		end
		if (rstb && inCreditReturn) begin
			creditPulses++;
			upCredits++;
		end
		assert (upCredits >= 0 && upCredits <= `FFE_IN_FIFO_DEPTH
			&& creditPulses <= sentBlocks.size())
			else stopOnError("input credit returned without a consumed block");
	end

	// downstream side, checks each result and returns credits after a delay.
	always @(negedge clk) begin
		int exp;
		outCreditReturn = 1'b0;
		if (rstb && outBlock.valid) begin
			assert (outCount < sentBlocks.size())
				else stopOnError("output block with no input left to match");
			assert (outCount < `FFE_OUT_CREDITS + returnsGiven)
				else stopOnError("output sent without a downstream credit");
			for (int c = 0; c < `FFE_CHANNELS; c++) begin
				exp = expectedResult(outCount, c);
				satHigh += (exp == satMax);
				satLow += (exp == satMin);
				assert ($signed(outBlock.results[c]) == exp)
					else stopOnError($sformatf("output %0d channel %0d is %0d, expected %0d",
						outCount, c, $signed(outBlock.results[c]), exp));
			end
			outCount++;
			pendingReturns++;
		end
		if (!withhold && pendingReturns > 0) begin
			if (rxGap > 0) begin
				rxGap--;
			end else begin
				outCreditReturn = 1'b1;
				pendingReturns--;
				returnsGiven++;
				rxState = xorshift(rxState);
				rxGap = rxState % 5;
			end
		end
	end

	task automatic queueBlocks(input int n);
		codeBlock_t b;
		for (int i = 0; i < n; i++) begin
			b = '0;
			for (int c = 0; c < `FFE_CHANNELS; c++) begin
				mainState = xorshift(mainState);
				b.codes[c] = mainState[`FFE_CODE_WIDTH-1:0];
			end
			txQueue.push_back(b);
		end
	endtask

	task automatic writeCfg(input cfgOp_t op, input int tap, input int channel, input int value);
		@(negedge clk);
		cfgCmd.op = op;
		cfgCmd.tap = tap;
		cfgCmd.channel = channel;
		cfgCmd.value = value;
		if (op == cfgWeight) begin
			modelWeight[tap][channel] = $signed(cfgCmd.value);
		end else if (op == cfgShift) begin
			modelShift[channel] = value % (2 ** `FFE_SHIFT_WIDTH);
		end
		@(negedge clk);
		cfgCmd.op = cfgNop;
	endtask

	task automatic waitDrained();
		int cycles = 0;
		while (txQueue.size() > 0 || outCount < sentBlocks.size() || pendingReturns > 0) begin
			@(negedge clk);
			cycles++;
			assert (cycles < 1000) else stopOnError("outputs stopped before every block came back");
		end
		repeat (3) @(negedge clk); // last credit return lands.
	endtask

	initial begin
		int base;
		int cycles;
		repeat (10) @(posedge clk);
		@(negedge clk);
		rstb = 1'b1;
		repeat (5) begin
			@(negedge clk);
			assert (!outBlock.valid && !inCreditReturn) else stopOnError("activity before any input");
		end
		queueBlocks(4); // zero coefficients give zero results.
		waitDrained();

		maxGap = 3;
		for (int t = 0; t < `FFE_DEPTH; t++) begin
			for (int c = 0; c < `FFE_CHANNELS; c++) begin
				mainState = xorshift(mainState);
				writeCfg(cfgWeight, t, c, int'(mainState % 5) - 2);
			end
		end
		for (int c = 0; c < `FFE_CHANNELS; c++) begin
			writeCfg(cfgShift, 0, c, 0);
		end
		queueBlocks(40);
		waitDrained();

		maxGap = 0;
		satHigh = 0; // count saturation of the shifted phase only.
		satLow = 0;
		for (int t = 0; t < `FFE_DEPTH; t++) begin
			for (int c = 0; c < `FFE_CHANNELS; c++) begin
				mainState = xorshift(mainState);
				writeCfg(cfgWeight, t, c, mainState[0] ? 127 - int'(mainState[4:1])
					: -128 + int'(mainState[4:1]));
			end
		end
		for (int s = 0; s < 8; s++) begin
			for (int c = 0; c < `FFE_CHANNELS; c++) begin
				writeCfg(cfgShift, 0, c, (s + c) % 8);
			end
			queueBlocks(8);
			waitDrained();
		end
		assert (satHigh > 0 && satLow > 0) else stopOnError("saturation limits never reached");

		// back-pressure. the core spends its credits and the FIFO fills up.
		withhold = 1'b1;
		base = outCount;
		cycles = 0;
		queueBlocks(6);
		while (txQueue.size() > 0) begin
			@(negedge clk);
			cycles++;
			assert (cycles < 200) else stopOnError("upstream burst was never accepted");
		end
		repeat (10) @(negedge clk);
		assert (outCount - base == `FFE_OUT_CREDITS && upCredits == 0
			&& creditPulses == sentBlocks.size() - `FFE_IN_FIFO_DEPTH)
			else stopOnError("stalled core did not hold with a full input FIFO");
		withhold = 1'b0;
		waitDrained();

		// nop with a random payload must not touch the coefficients.
		repeat (3) begin
			@(negedge clk);
			mainState = xorshift(mainState);
			cfgCmd = mainState[$bits(cfgCmd_t)-1:0];
			cfgCmd.op = cfgNop;
		end
		writeCfg(cfgWeight, 0, 1, 9);
		writeCfg(cfgWeight, 5, 3, -7);
		writeCfg(cfgShift, 0, 2, 3);
		writeCfg(cfgShift, 0, 0, 1);
		maxGap = 2;
		queueBlocks(16);
		waitDrained();

		if (outCount == sentBlocks.size() && creditPulses == sentBlocks.size()
			&& upCredits == `FFE_IN_FIFO_DEPTH) begin
			$display("TESTS PASSED");
			$finish;
		end else begin
			stopOnError("block or credit counts do not match at the end");
		end
	end

	initial begin
		#(runLimit);
		$display("Timeout: the run did not finish within %0d ns", runLimit);
		$display("TESTS FAILED");
		$fatal(1, "watchdog expired");
	end

endmodule : ffe_tb

`default_nettype wire

// ==== ffe_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module ffe_top (
	input wire logic clk,
	input wire logic rstb,
	input wire ffe_pkg::codeBlock_t inBlock,
	output logic inCreditReturn,
	input wire ffe_pkg::cfgCmd_t cfgCmd,
	output ffe_pkg::resultBlock_t outBlock,
	input wire logic outCreditReturn
);
	import ffe_pkg::*;

	codeBlock_t headBlock;
	logic notEmpty;
	logic pop;
	weightSet_t weights;
	shiftSet_t shiftIndex;

	ffe_credit_in inFifo (
		.clk(clk),
		.rstb(rstb),
		.inBlock(inBlock),
		.pop(pop),
		.outBlock(headBlock),
		.notEmpty(notEmpty),
		.inCreditReturn(inCreditReturn)
	);

	ffe_coef_regs coefRegs (
		.clk(clk),
		.rstb(rstb),
		.cfgCmd(cfgCmd),
		.weights(weights),
		.shiftIndex(shiftIndex)
	);

	flat_ffe core (
		.clk(clk),
		.rstb(rstb),
		.inBlock(headBlock),
		.notEmpty(notEmpty),
		.weights(weights),
		.shiftIndex(shiftIndex),
		.outCreditReturn(outCreditReturn),
		.pop(pop),
		.outBlock(outBlock)
	);

endmodule : ffe_top

`default_nettype wire

// ==== flat_ffe.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "ffe_defs.svh"

module flat_ffe (
	input wire logic clk,
	input wire logic rstb,
	input wire ffe_pkg::codeBlock_t inBlock,
	input wire logic notEmpty,
	input wire ffe_pkg::weightSet_t weights,
	input wire ffe_pkg::shiftSet_t shiftIndex,
	input wire logic outCreditReturn,
	output logic pop,
	output ffe_pkg::resultBlock_t outBlock
);
	import ffe_pkg::*;

	localparam int creditWidth = $clog2(`FFE_OUT_CREDITS + 1);
	localparam int numCodes = `FFE_CHANNELS * `FFE_BUFFER_DEPTH;

	logic advance;
	logic [creditWidth-1:0] credits;
	logic [numCodes-1:0][`FFE_CODE_WIDTH-1:0] flatCodes;
	result_t [`FFE_CHANNELS-1:0] nextResults;
	result_t [`FFE_CHANNELS-1:0] results;
	logic resultValid;

	// move only with a block waiting and room downstream.
	assign advance = notEmpty && (credits != '0);
	assign pop = advance;

	code_buffer #(
		.numChannels(`FFE_CHANNELS),
		.bitwidth(`FFE_CODE_WIDTH),
		.depth(`FFE_BUFFER_DEPTH)
	) codeBuf (
		.clk(clk),
		.rstb(rstb),
		.advance(advance),
		.in(inBlock),
		.flatCodes(flatCodes)
	);

	comb_ffe #(
		.ffeDepth(`FFE_DEPTH),
		.numChannels(`FFE_CHANNELS),
		.numBuffers(`FFE_BUFFER_DEPTH),
		.centerBuffer(`FFE_CENTER_BUFFER)
	) combFfe (
		.weights(weights),
		.shiftIndex(shiftIndex),
		.flatCodes(flatCodes),
		.estimatedCodes(nextResults)
	);

	always_ff @(posedge clk) begin
		if (advance) begin
			results <= nextResults;
		end
	end

	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			resultValid <= 1'b0;
			credits <= creditWidth'(`FFE_OUT_CREDITS);
		end else begin
			resultValid <= advance;
			// credit taken at advance, it pays for the valid one cycle later.
			case ({advance, outCreditReturn})
				2'b10: credits <= credits - 1'b1;
				2'b01: credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
		end
	end

	always_comb begin
		outBlock.valid = resultValid;
		outBlock.results = results;
	end

endmodule : flat_ffe

`default_nettype wire

// ==== sources.f ====
+incdir+.
ffe_pkg.sv
ffe_credit_in.sv
code_buffer.sv
comb_ffe.sv
ffe_coef_regs.sv
flat_ffe.sv
ffe_top.sv
ffe_tb.sv
